/* vlog.f */
src/cpu_bus_pkg.sv
src/cpu_bus_if.sv
src/bus_out_lane.sv
src/bus_in_lane.sv
src/bus_handler.sv
src/cpu_core.sv
src/cpu_bus_top.sv
verification/tb_cpu_bus_top.sv

/* Bender.yml */
package:
  name: cpu_bus

sources:
  - files:
      - src/cpu_bus_pkg.sv
      - src/cpu_bus_if.sv
      - src/bus_out_lane.sv
      - src/bus_in_lane.sv
      - src/bus_handler.sv
      - src/cpu_core.sv
      - src/cpu_bus_top.sv
  - target: test
    files:
      - verification/tb_cpu_bus_top.sv

/* verification/tb_cpu_bus_top.sv */
`timescale 1ns/1ps

module tb_cpu_bus_top import cpu_bus_pkg::*; ();

  localparam logic [WORD_W-1:0] RESET_PC = 32'h0000_0010;
  localparam int N_INSTR    = 21;                              // Instructions executed
  localparam int N_FRAMES   = 2 * N_INSTR;
  localparam int MAX_CYCLES = FRAME_LEN * 2 * N_INSTR + 200;

  // One bus frame as seen on the pins
  typedef struct packed {
    logic [WORD_W-1:0] addr;
    logic [WORD_W-1:0] wdata;
    logic [PIN_W-1:0]  oe;
  } frame_t;

  logic             clk;
  logic             rst_n;
  logic [PIN_W-1:0] uio_in;
  logic [PIN_W-1:0] uo_out;
  logic [PIN_W-1:0] uio_out;
  logic [PIN_W-1:0] uio_oe;
  logic             frame_start;

  logic [WORD_W-1:0] mem [256];      // Memory behind the pins
  logic [WORD_W-1:0] ref_mem [256];  // Reference copy
  logic [WORD_W-1:0] m_pc;
  logic [WORD_W-1:0] m_acc;
  logic              m_fetch;        // Next frame is a fetch
  logic [31:0]       lcg_state;
  frame_t            obs_q[$];       // Frames seen by the memory model

  cpu_bus_top #(
    .RESET_PC (RESET_PC)
  ) DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .uio_in      (uio_in),
    .uo_out      (uo_out),
    .uio_out     (uio_out),
    .uio_oe      (uio_oe),
    .frame_start (frame_start)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] encode_instr(input logic [3:0] op, input logic [15:0] operand);
    return {op, 12'h000, operand};
  endfunction

  // Advances the pc/acc model by one frame and returns what the pins should show
  function automatic frame_t predict_frame();
    frame_t            f;
    logic [WORD_W-1:0] ir;
    logic [WORD_W-1:0] operand;
    logic [WORD_W-1:0] data;
    logic [3:0]        op;
    f.wdata = '0;
    f.oe    = 8'h00;
    if (m_fetch) begin
      f.addr  = m_pc;
      m_fetch = 1'b0;
    end else begin
      ir      = ref_mem[m_pc[7:0]];
      op      = ir[31:28];
      operand = {16'h0000, ir[15:0]};
      data    = ref_mem[operand[7:0]];
      f.addr  = operand;  // Every execute frame targets the operand
      case (op)
        OP_LOAD:  m_acc = data;
        OP_ADD:   m_acc = m_acc + data;
        OP_SUB:   m_acc = m_acc - data;
        OP_AND:   m_acc = m_acc & data;
        OP_STORE: begin
          f.wdata = m_acc;
          f.oe    = 8'hFF;
          ref_mem[operand[7:0]] = m_acc;
        end
        default: ;  // NOP, jumps and undefined codes
      endcase
      if (op == OP_JMP || (op == OP_JZ && m_acc == '0)) begin
        m_pc = operand;
      end else begin
        m_pc = m_pc + 1;
      end
      m_fetch = 1'b1;
    end
    return f;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch at time %0t: %s got %h expected %h", $realtime, name, got, exp);
      $display("TB FAILED");
      $fatal(1, "Value check failed");
    end
  endtask

  initial begin : clock_gen
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin : setup_and_reset
    int i;
    rst_n     = 1'b0;
    lcg_state = 32'h2f58d18c;
    for (i = 0; i < 256; i++) begin
      mem[i] = 32'h5A5A_0000 + i;  // Marks untouched words by address
    end
    for (i = 8'h80; i <= 8'h87; i++) begin
      mem[i] = lcg_next();
    end
    mem[8'h86] = lcg_next() | 32'h1;  // Never zero
    mem[8'h10] = encode_instr(OP_LOAD,  16'h0080);
    mem[8'h11] = encode_instr(OP_STORE, 16'h00A0);
    mem[8'h12] = encode_instr(OP_ADD,   16'h0081);
    mem[8'h13] = encode_instr(OP_STORE, 16'h00A1);
    mem[8'h14] = encode_instr(OP_SUB,   16'h0082);
    mem[8'h15] = encode_instr(OP_STORE, 16'h00A2);
    mem[8'h16] = encode_instr(OP_AND,   16'h0083);
    mem[8'h17] = encode_instr(4'hF,     16'h0084);  // Undefined
    mem[8'h18] = encode_instr(4'h9,     16'h0085);  // Undefined
    mem[8'h19] = encode_instr(OP_STORE, 16'h00A3);  // Still the AND result
    mem[8'h1A] = encode_instr(OP_LOAD,  16'h0086);
    mem[8'h1B] = encode_instr(OP_JZ,    16'h0040);  // Not taken
    mem[8'h1C] = encode_instr(OP_JMP,   16'h0020);
    mem[8'h1D] = encode_instr(OP_STORE, 16'h00AF);  // Skipped
    mem[8'h20] = encode_instr(OP_SUB,   16'h0086);  // acc becomes zero
    mem[8'h21] = encode_instr(OP_JZ,    16'h0028);  // Taken
    mem[8'h22] = encode_instr(OP_STORE, 16'h00AE);  // Skipped
    mem[8'h28] = encode_instr(OP_LOAD,  16'h00A1);  // Read back a stored word
    mem[8'h29] = encode_instr(OP_ADD,   16'h0087);
    mem[8'h2A] = encode_instr(OP_STORE, 16'h00A4);
    mem[8'h2B] = encode_instr(OP_JMP,   16'h002B);  // Spin
    for (i = 0; i < 256; i++) begin
      ref_mem[i] = mem[i];
    end
    m_pc    = RESET_PC;
    m_acc   = '0;
    m_fetch = 1'b1;
    repeat (4) @(posedge clk);
    #0.5;
    rst_n = 1'b1;
  end

  // Plays the memory side of each 9-cycle frame
  initial begin : bus_model
    frame_t     f;
    logic [7:0] idx;
    int         n;
    int         cyc;
    uio_in = '0;
    wait (rst_n === 1'b1);
    @(negedge clk);
    while (frame_start !== 1'b1) @(negedge clk);
    check_value("uio_oe", uio_oe, 32'h0);
    for (n = 0; n < N_FRAMES; n++) begin
      if (n > 0) begin
        @(negedge clk);
      end
      check_value("frame_start", frame_start, 32'h1);
      check_value("uo_out", uo_out, 32'h0);
      check_value("uio_out", uio_out, 32'h0);
      for (cyc = 1; cyc < FRAME_LEN; cyc++) begin
        @(posedge clk);
        #0.5;
        if (cyc >= 5) begin
          uio_in = mem[idx][8*(cyc-5) +: 8];  // Read byte cyc-5
        end else begin
          uio_in = '0;
        end
        @(negedge clk);
        check_value("frame_start", frame_start, 32'h0);
        if (cyc >= 2 && cyc <= 5) begin
          f.addr[8*(cyc-2) +: 8]  = uo_out;
          f.wdata[8*(cyc-2) +: 8] = uio_out;
          if (cyc == 2) begin
            f.oe = uio_oe;
            idx  = uo_out;  // Low address byte picks the word
          end else begin
            check_value("uio_oe", uio_oe, f.oe);
          end
        end else begin
          check_value("uo_out", uo_out, 32'h0);
          check_value("uio_out", uio_out, 32'h0);
          if (cyc > 5) begin
            check_value("uio_oe", uio_oe, f.oe);
          end
        end
      end
      if (f.oe == 8'hFF) begin
        mem[idx] = f.wdata;
      end
      obs_q.push_back(f);
    end
  end

  initial begin : compare_frames
    frame_t got;
    frame_t exp;
    int     n;
    int     i;
    for (n = 0; n < N_FRAMES; n++) begin
      while (obs_q.size() == 0) @(posedge clk);
      got = obs_q.pop_front();
      exp = predict_frame();
      check_value("uo_out address", got.addr, exp.addr);
      check_value("uio_oe", got.oe, exp.oe);
      check_value("uio_out data", got.wdata, exp.wdata);
    end
    for (i = 8'hA0; i <= 8'hAF; i++) begin
      check_value("memory result", mem[i], ref_mem[i]);
    end
    $display("TB PASSED");
    $finish;
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the frames did not all arrive within %0d cycles", MAX_CYCLES);
    $display("TB FAILED");
    $fatal(1, "Timeout");
  end

endmodule

/* src/cpu_bus_top.sv */
`timescale 1ns/1ps

module cpu_bus_top import cpu_bus_pkg::*; #(
  parameter logic [WORD_W-1:0] RESET_PC = '0
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [PIN_W-1:0] uio_in,
  output logic [PIN_W-1:0] uo_out,   // Address bytes
  output logic [PIN_W-1:0] uio_out,  // Write data bytes
  output logic [PIN_W-1:0] uio_oe,
  output logic             frame_start
);

  cpu_bus_if bus_if ();

  cpu_core #(
    .RESET_PC (RESET_PC)
  ) u_core (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (bus_if.core)
  );

  bus_handler u_handler (
    .clk         (clk),
    .rst_n       (rst_n),
    .pin_in      (uio_in),
    .pin_addr    (uo_out),
    .pin_data    (uio_out),
    .pin_oe      (uio_oe),
    .frame_start (frame_start),
    .bus         (bus_if.handler)
  );

endmodule

/* src/cpu_core.sv */
`timescale 1ns/1ps

module cpu_core import cpu_bus_pkg::*; #(
  parameter logic [WORD_W-1:0] RESET_PC = '0
) (
  input  logic    clk,
  input  logic    rst_n,
  cpu_bus_if.core bus
);

  // Kind of frame the next step starts
  typedef enum logic {
    ST_FETCH,
    ST_EXEC
  } cpu_state_e;

  cpu_state_e        state;
  logic [WORD_W-1:0] pc;        // Address of the next fetch
  logic [WORD_W-1:0] acc;
  logic [WORD_W-1:0] ir;        // Instruction in its execute frame
  logic [WORD_W-1:0] acc_next;
  logic [WORD_W-1:0] operand;   // Of the word just fetched
  opcode_e           ir_op;
  opcode_e           new_op;
  logic              jump_taken;

  assign ir_op   = opcode_e'(ir[31:28]);
  assign new_op  = opcode_e'(bus.rdata[31:28]);
  assign operand = WORD_W'(bus.rdata[15:0]);

  // acc is already current when the jump is decoded
  assign jump_taken = (new_op == OP_JMP) || (new_op == OP_JZ && acc == '0);

  // Result of the execute frame, read word in rdata
  always_comb begin
    case (ir_op)
      OP_LOAD: acc_next = bus.rdata;
      OP_ADD:  acc_next = acc + bus.rdata;
      OP_SUB:  acc_next = acc - bus.rdata;
      OP_AND:  acc_next = acc & bus.rdata;
      default: acc_next = acc;  // NOP, STORE, jumps, undefined
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= ST_FETCH;
      pc        <= RESET_PC;
      acc       <= '0;
      ir        <= '0;  // Behaves as NOP on the first step
      bus.addr  <= RESET_PC;
      bus.wdata <= '0;
      bus.rw    <= 1'b1;
    end else if (bus.step) begin
      case (state)
        ST_FETCH: begin
          acc       <= acc_next;
          bus.addr  <= pc;
          bus.wdata <= '0;
          bus.rw    <= 1'b1;
          state     <= ST_EXEC;
        end
        default: begin
          // Fetched word is in rdata, issue the operand access
          ir        <= bus.rdata;
          bus.addr  <= operand;
          bus.wdata <= acc;
          bus.rw    <= (new_op != OP_STORE);
          pc        <= jump_taken ? operand : pc + 1'b1;
          state     <= ST_FETCH;
        end
      endcase
    end
  end

  // Writes only come out of a STORE's execute frame
  a_write_store : assert property (
    @(posedge clk) disable iff (!rst_n)
    !bus.rw |-> (state == ST_FETCH) && (ir_op == OP_STORE)
  );

endmodule

/* src/bus_handler.sv */
`timescale 1ns/1ps

module bus_handler import cpu_bus_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [PIN_W-1:0] pin_in,
  output logic [PIN_W-1:0] pin_addr,
  output logic [PIN_W-1:0] pin_data,
  output logic [PIN_W-1:0] pin_oe,
  output logic             frame_start,
  cpu_bus_if.handler       bus
);

  bus_phase_e        phase;
  logic              step;
  logic              last_phase;
  logic [WORD_W-1:0] word;
  logic              word_done;

  assign last_phase = (phase == bus_phase_e'(FRAME_LEN - 1));

  // Free-running frame counter, step is registered alongside it
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      phase <= PH_STEP;
      step  <= 1'b1;  // First cycle out of reset starts a frame
    end else begin
      phase <= last_phase ? PH_STEP : bus_phase_e'(phase + 1'b1);
      step  <= last_phase;
    end
  end

  assign frame_start = step;
  assign bus.step    = step;
  assign bus.rdata   = word;

  bus_out_lane u_out_lane (
    .clk      (clk),
    .rst_n    (rst_n),
    .phase    (phase),
    .addr     (bus.addr),
    .wdata    (bus.wdata),
    .rw       (bus.rw),
    .pin_addr (pin_addr),
    .pin_data (pin_data),
    .pin_oe   (pin_oe)
  );

  bus_in_lane u_in_lane (
    .clk       (clk),
    .rst_n     (rst_n),
    .phase     (phase),
    .pin_in    (pin_in),
    .word      (word),
    .word_done (word_done)
  );

  a_step_phase : assert property (
    @(posedge clk) disable iff (!rst_n)
    step |-> phase == PH_STEP
  );

  // The CPU may only move its request on a step
  a_rw_hold : assert property (
    @(posedge clk) disable iff (!rst_n)
    $changed(bus.rw) |-> $past(step)
  );

  // Read word lands in the last phase, right before the next step
  a_word_timing : assert property (
    @(posedge clk) disable iff (!rst_n)
    step |-> ##(FRAME_LEN-1) word_done ##1 step
  );

endmodule

/* src/bus_in_lane.sv */
`timescale 1ns/1ps

module bus_in_lane import cpu_bus_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  bus_phase_e        phase,
  input  logic [PIN_W-1:0]  pin_in,
  output logic [WORD_W-1:0] word,
  output logic              word_done
);

  logic [WORD_W-1:0] shadow;    // Bytes collected so far
  logic              in_phase;  // One of PH_IN0..PH_IN3
  logic [1:0]        byte_sel;

  assign in_phase  = (phase >= PH_IN0);
  assign byte_sel  = 2'(phase - PH_IN0);
  assign word_done = (phase == PH_IN3);  // Word completes at this edge

  always_ff @(posedge clk) begin
    if (in_phase) begin
      shadow[PIN_W*byte_sel +: PIN_W] <= pin_in;
    end
  end

  // Top byte arrives on the same edge that publishes the word
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      word <= '0;
    end else if (word_done) begin
      word <= {pin_in, shadow[WORD_W-PIN_W-1:0]};
    end
  end

endmodule

/* src/bus_out_lane.sv */
`timescale 1ns/1ps

module bus_out_lane import cpu_bus_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  bus_phase_e        phase,
  input  logic [WORD_W-1:0] addr,
  input  logic [WORD_W-1:0] wdata,
  input  logic              rw,
  output logic [PIN_W-1:0]  pin_addr,
  output logic [PIN_W-1:0]  pin_data,
  output logic [PIN_W-1:0]  pin_oe
);

  logic       out_phase;  // One of PH_OUT0..PH_OUT3
  logic [1:0] byte_sel;   // Byte index within the word

  assign out_phase = (phase >= PH_OUT0) && (phase <= PH_OUT3);
  assign byte_sel  = 2'(phase - PH_OUT0);

  // Pins lag the phase by one cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pin_addr <= '0;
      pin_data <= '0;
      pin_oe   <= '0;
    end else begin
      pin_oe <= rw ? '0 : '1;  // Whole frame follows the request
      if (out_phase) begin
        pin_addr <= addr[PIN_W*byte_sel +: PIN_W];
        pin_data <= rw ? '0 : wdata[PIN_W*byte_sel +: PIN_W];  // Quiet on reads
      end else begin
        pin_addr <= '0;
        pin_data <= '0;
      end
    end
  end

  // The enable only flips with a new request, seen on the pins one phase later
  a_oe_frame : assert property (
    @(posedge clk) disable iff (!rst_n)
    (pin_oe == '0 || pin_oe == '1) &&
    ($changed(pin_oe) -> $past(phase) == PH_OUT0)
  );

endmodule

/* src/cpu_bus_if.sv */
`timescale 1ns/1ps

interface cpu_bus_if import cpu_bus_pkg::*; ();

  logic [WORD_W-1:0] addr;   // Request address
  logic [WORD_W-1:0] wdata;  // Write data
  logic              rw;     // 1 = read, 0 = write
  logic              step;   // One-cycle pulse in PH_STEP
  logic [WORD_W-1:0] rdata;  // Word read in the previous frame

  modport core (
    output addr,
    output wdata,
    output rw,
    input  step,
    input  rdata
  );

  modport handler (
    input  addr,
    input  wdata,
    input  rw,
    output step,
    output rdata
  );

endinterface

/* src/cpu_bus_pkg.sv */
package cpu_bus_pkg;

  localparam int WORD_W    = 32;  // Data and address word
  localparam int PIN_W     = 8;   // Pin bus width
  localparam int FRAME_LEN = 9;   // Phases per bus frame

  // One bus frame, one phase per clock
  typedef enum logic [3:0] {
    PH_STEP = 4'd0,  // CPU steps here
    PH_OUT0 = 4'd1,  // Address and write data, byte 0
    PH_OUT1 = 4'd2,
    PH_OUT2 = 4'd3,
    PH_OUT3 = 4'd4,
    PH_IN0  = 4'd5,  // Read data, byte 0
    PH_IN1  = 4'd6,
    PH_IN2  = 4'd7,
    PH_IN3  = 4'd8   // Last phase, wraps to PH_STEP
  } bus_phase_e;

  // Instruction opcode in bits 31:28, operand in bits 15:0
  typedef enum logic [3:0] {
    OP_NOP   = 4'h0,
    OP_LOAD  = 4'h1,  // acc = mem[op]
    OP_STORE = 4'h2,  // mem[op] = acc
    OP_ADD   = 4'h3,  // acc = acc + mem[op]
    OP_SUB   = 4'h4,  // acc = acc - mem[op]
    OP_AND   = 4'h5,  // acc = acc & mem[op]
    OP_JMP   = 4'h6,  // pc = op
    OP_JZ    = 4'h7   // pc = op when acc is zero
  } opcode_e;

endpackage
